// ==== rtl/stats_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared constants for the retire-trace statistics unit.
// Counter indices, opcode encodings, marker words and the
// readout credit budget, all used by scoped name.
////////////////////////////////////////////////////////////
`default_nettype none

package stats_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    localparam int RETIRE_PORTS = 2;
    localparam int INSTR_W = 32;
    localparam int COUNT_W = 32;
    // Two ports can hit the same category in one cycle
    localparam int INC_W = 2;

    ////////////////////////////////////////////////////////////
    // Both window markers are addi x0, x0, imm
    localparam logic [INSTR_W-1:0] START_MARKER = 32'h00C00013;
    localparam logic [INSTR_W-1:0] END_MARKER = 32'h00D00013;

    ////////////////////////////////////////////////////////////
    // Major opcodes from instruction bits 6:2
    localparam logic [4:0] OPC_ARITH = 5'b01100;
    localparam logic [4:0] OPC_ARITH_IMM = 5'b00100;
    localparam logic [4:0] OPC_AUIPC = 5'b00101;
    localparam logic [4:0] OPC_LUI = 5'b01101;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JAL = 5'b11011;
    localparam logic [4:0] OPC_JALR = 5'b11001;
    localparam logic [4:0] OPC_LOAD = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;
    localparam logic [4:0] OPC_FENCE = 5'b00011;

    // Split of the arithmetic group into mul and div
    localparam int MULDIV_BIT = 25;
    localparam int DIV_BIT = 14;

    ////////////////////////////////////////////////////////////
    // Counter indices
    localparam int CNT_ALU = 0;
    localparam int CNT_BR = 1;
    localparam int CNT_MUL = 2;
    localparam int CNT_DIV = 3;
    localparam int CNT_LOAD = 4;
    localparam int CNT_STORE = 5;
    localparam int CNT_MISC = 6;
    localparam int CNT_STALL_NO_INSTR = 7;
    localparam int CNT_STALL_UNIT_BUSY = 8;
    localparam int CNT_STALL_OPERANDS = 9;
    localparam int CNT_STALL_HOLD = 10;
    localparam int CNT_STALL_MULTI = 11;

    localparam int NUM_MIX = CNT_MISC + 1;
    localparam int NUM_STALL = CNT_STALL_MULTI - CNT_STALL_NO_INSTR + 1;
    localparam int NUM_COUNTERS = 12;

    ////////////////////////////////////////////////////////////
    // Readout
    localparam int IDX_W = 4;
    localparam int CREDITS = 4;
    localparam int CREDIT_W = 3;

endpackage

`default_nettype wire

// ==== rtl/retire_classifier.sv ====
////////////////////////////////////////////////////////////
// Sorts retired instructions into mix categories and flags
// the window markers. Outputs are one cycle behind retire.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retire_classifier (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic [stats_pkg::RETIRE_PORTS-1:0] retire_valid,
    input  wire logic [stats_pkg::RETIRE_PORTS-1:0][stats_pkg::INSTR_W-1:0] retire_instr,
    output logic [stats_pkg::NUM_MIX-1:0][stats_pkg::INC_W-1:0] mix_inc,
    output logic start_seen,
    output logic end_seen
);

    logic [stats_pkg::RETIRE_PORTS-1:0][4:0] opc;
    logic [stats_pkg::RETIRE_PORTS-1:0] port_start;
    logic [stats_pkg::RETIRE_PORTS-1:0] port_end;
    logic [stats_pkg::RETIRE_PORTS-1:0][stats_pkg::NUM_MIX-1:0] port_cat;
    logic [stats_pkg::NUM_MIX-1:0][stats_pkg::INC_W-1:0] mix_d;
    // Sum of the registered increments over all categories
    logic [4:0] mix_total;

    always_comb begin
        port_cat = '0;
        for (int p = 0; p < stats_pkg::RETIRE_PORTS; p++) begin
            opc[p] = retire_instr[p][6:2];
            port_start[p] = retire_valid[p] && (retire_instr[p] == stats_pkg::START_MARKER);
            port_end[p] = retire_valid[p] && (retire_instr[p] == stats_pkg::END_MARKER);
            // Markers never enter the mix
            if (retire_valid[p] && !port_start[p] && !port_end[p]) begin
                if (opc[p] == stats_pkg::OPC_ARITH && retire_instr[p][stats_pkg::MULDIV_BIT]) begin
                    if (retire_instr[p][stats_pkg::DIV_BIT])
                        port_cat[p][stats_pkg::CNT_DIV] = 1'b1;
                    else
                        port_cat[p][stats_pkg::CNT_MUL] = 1'b1;
                end else if (opc[p] inside {stats_pkg::OPC_ARITH, stats_pkg::OPC_ARITH_IMM,
                                            stats_pkg::OPC_AUIPC, stats_pkg::OPC_LUI}) begin
                    port_cat[p][stats_pkg::CNT_ALU] = 1'b1;
                end else if (opc[p] inside {stats_pkg::OPC_BRANCH, stats_pkg::OPC_JAL,
                                            stats_pkg::OPC_JALR}) begin
                    port_cat[p][stats_pkg::CNT_BR] = 1'b1;
                end else if (opc[p] == stats_pkg::OPC_LOAD) begin
                    port_cat[p][stats_pkg::CNT_LOAD] = 1'b1;
                end else if (opc[p] == stats_pkg::OPC_STORE) begin
                    port_cat[p][stats_pkg::CNT_STORE] = 1'b1;
                end else begin
                    // System, fence and anything unmodeled such as atomics
                    port_cat[p][stats_pkg::CNT_MISC] = 1'b1;
                end
            end
        end

        // Per-category sum over the ports
        for (int c = 0; c < stats_pkg::NUM_MIX; c++) begin
            mix_d[c] = '0;
            for (int p = 0; p < stats_pkg::RETIRE_PORTS; p++)
                mix_d[c] = mix_d[c] + {{(stats_pkg::INC_W-1){1'b0}}, port_cat[p][c]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mix_inc <= '0;
            start_seen <= 1'b0;
            end_seen <= 1'b0;
        end else begin
            mix_inc <= mix_d;
            start_seen <= |port_start;
            end_seen <= |port_end;
        end
    end

    always_comb begin
        mix_total = '0;
        for (int c = 0; c < stats_pkg::NUM_MIX; c++)
            mix_total = mix_total + {3'b000, mix_inc[c]};
    end

    // Each retired word adds to one category at most
    a_one_category: assert property (@(posedge clk) disable iff (!arst_n)
        mix_total <= $past(5'($countones(retire_valid))))
        else $error("mix increments exceed the words retired a cycle earlier");

endmodule

`default_nettype wire

// ==== rtl/stall_classifier.sv ====
////////////////////////////////////////////////////////////
// Charges each issue-stall cycle to its single source, or
// to the multi-source bucket. Output is registered.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module stall_classifier (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic stall_no_instr,
    input  wire logic stall_unit_busy,
    input  wire logic stall_operands,
    input  wire logic stall_hold,
    output logic [stats_pkg::NUM_STALL-1:0] stall_inc
);

    // Bit positions inside stall_inc, relative to the first stall counter
    localparam int B_NO_INSTR = stats_pkg::CNT_STALL_NO_INSTR - stats_pkg::NUM_MIX;
    localparam int B_UNIT_BUSY = stats_pkg::CNT_STALL_UNIT_BUSY - stats_pkg::NUM_MIX;
    localparam int B_OPERANDS = stats_pkg::CNT_STALL_OPERANDS - stats_pkg::NUM_MIX;
    localparam int B_HOLD = stats_pkg::CNT_STALL_HOLD - stats_pkg::NUM_MIX;
    localparam int B_MULTI = stats_pkg::CNT_STALL_MULTI - stats_pkg::NUM_MIX;

    logic [2:0] active;
    logic [stats_pkg::NUM_STALL-1:0] stall_d;

    assign active = {2'b00, stall_no_instr} + {2'b00, stall_unit_busy}
                  + {2'b00, stall_operands} + {2'b00, stall_hold};

    always_comb begin
        stall_d = '0;
        if (active == 3'd1) begin
            stall_d[B_NO_INSTR] = stall_no_instr;
            stall_d[B_UNIT_BUSY] = stall_unit_busy;
            stall_d[B_OPERANDS] = stall_operands;
            stall_d[B_HOLD] = stall_hold;
        end else if (active > 3'd1) begin
            stall_d[B_MULTI] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            stall_inc <= '0;
        else
            stall_inc <= stall_d;
    end

endmodule

`default_nettype wire

// ==== rtl/counter_bank.sv ====
////////////////////////////////////////////////////////////
// Saturating event counters with a synchronous clear and a
// registered read port. Response follows accept by a cycle.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module counter_bank #(
    parameter int NUM_EVENTS = stats_pkg::NUM_COUNTERS
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic [stats_pkg::NUM_MIX-1:0][stats_pkg::INC_W-1:0] mix_inc,
    input  wire logic [stats_pkg::NUM_STALL-1:0] stall_inc,
    input  wire logic count_en,
    input  wire logic count_clr,
    input  wire logic rd_accept,
    input  wire logic [stats_pkg::IDX_W-1:0] rd_index,
    output logic rsp_valid,
    output logic [stats_pkg::IDX_W-1:0] rsp_index,
    output logic [stats_pkg::COUNT_W-1:0] rsp_data
);

    logic [stats_pkg::COUNT_W-1:0] counters [NUM_EVENTS];
    wire [NUM_EVENTS-1:0][stats_pkg::INC_W-1:0] event_inc;

    function automatic logic [stats_pkg::COUNT_W-1:0] sat_add(
        input logic [stats_pkg::COUNT_W-1:0] cnt,
        input logic [stats_pkg::INC_W-1:0] inc
    );
        logic [stats_pkg::COUNT_W:0] sum;
        sum = {1'b0, cnt} + {{(stats_pkg::COUNT_W + 1 - stats_pkg::INC_W){1'b0}}, inc};
        // Stick at all ones on overflow
        return sum[stats_pkg::COUNT_W] ? '1 : sum[stats_pkg::COUNT_W-1:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Mix increments first, then stall bits, then unused slots
    for (genvar i = 0; i < NUM_EVENTS; i++) begin : g_inc
        if (i < stats_pkg::NUM_MIX) begin : g_mix
            assign event_inc[i] = mix_inc[i];
        end else if (i < stats_pkg::NUM_MIX + stats_pkg::NUM_STALL) begin : g_stall
            assign event_inc[i] = {{(stats_pkg::INC_W-1){1'b0}},
                                   stall_inc[i - stats_pkg::NUM_MIX]};
        end else begin : g_none
            assign event_inc[i] = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_EVENTS; i++)
                counters[i] <= '0;
        end else if (count_clr) begin
            for (int i = 0; i < NUM_EVENTS; i++)
                counters[i] <= '0;
        end else if (count_en) begin
            for (int i = 0; i < NUM_EVENTS; i++)
                counters[i] <= sat_add(counters[i], event_inc[i]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= rd_accept;
    end

    // Value as it stood at the accept edge
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rsp_index <= rd_index;
            if (rd_index < NUM_EVENTS)
                rsp_data <= counters[rd_index];
            else
                rsp_data <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/collection_ctrl.sv ====
////////////////////////////////////////////////////////////
// Collection window FSM driven by the marker flags, plus
// the credit count that paces readout requests.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module collection_ctrl (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic start_seen,
    input  wire logic end_seen,
    input  wire logic rd_valid,
    input  wire logic rsp_credit,
    output logic count_en,
    output logic count_clr,
    output logic collecting,
    output logic collection_done,
    output logic rd_ready,
    output logic rd_accept
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_DONE
    } state_t;

    state_t state;
    logic [stats_pkg::CREDIT_W-1:0] credits;

    ////////////////////////////////////////////////////////////
    // Window
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            // A start marker restarts the window from any state
            if (start_seen)
                state <= ST_COLLECT;
            else if (end_seen && state == ST_COLLECT)
                state <= ST_DONE;
        end
    end

    // Clear lands in the cycle the window opens
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            count_clr <= 1'b0;
        else
            count_clr <= start_seen;
    end

    assign collecting = (state == ST_COLLECT);
    assign collection_done = (state == ST_DONE);
    assign count_en = collecting;

    ////////////////////////////////////////////////////////////
    // Readout credits
    assign rd_ready = (credits != '0);
    assign rd_accept = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= stats_pkg::CREDITS[stats_pkg::CREDIT_W-1:0];
        end else begin
            case ({rd_accept, rsp_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // A credit with no outstanding response pushes the count past the budget
    a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        credits <= stats_pkg::CREDITS)
        else $error("readout credit returned with no response outstanding");

endmodule

`default_nettype wire

// ==== rtl/retire_stats_top.sv ====
////////////////////////////////////////////////////////////
// Retire-trace statistics unit. Classifies retired words
// and stall cycles inside the marker window and serves the
// counters through a credit-paced read port.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retire_stats_top (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic [stats_pkg::RETIRE_PORTS-1:0] retire_valid,
    input  wire logic [stats_pkg::RETIRE_PORTS-1:0][stats_pkg::INSTR_W-1:0] retire_instr,
    input  wire logic stall_no_instr,
    input  wire logic stall_unit_busy,
    input  wire logic stall_operands,
    input  wire logic stall_hold,
    input  wire logic rd_valid,
    input  wire logic [stats_pkg::IDX_W-1:0] rd_index,
    output logic rd_ready,
    output logic rsp_valid,
    output logic [stats_pkg::IDX_W-1:0] rsp_index,
    output logic [stats_pkg::COUNT_W-1:0] rsp_data,
    input  wire logic rsp_credit,
    output logic collecting,
    output logic collection_done
);

    logic [stats_pkg::NUM_MIX-1:0][stats_pkg::INC_W-1:0] mix_inc;
    logic [stats_pkg::NUM_STALL-1:0] stall_inc;
    logic start_seen;
    logic end_seen;
    logic count_en;
    logic count_clr;
    logic rd_accept;

    retire_classifier retire_cls (
        .clk          (clk),
        .arst_n       (arst_n),
        .retire_valid (retire_valid),
        .retire_instr (retire_instr),
        .mix_inc      (mix_inc),
        .start_seen   (start_seen),
        .end_seen     (end_seen)
    );

    stall_classifier stall_cls (
        .clk             (clk),
        .arst_n          (arst_n),
        .stall_no_instr  (stall_no_instr),
        .stall_unit_busy (stall_unit_busy),
        .stall_operands  (stall_operands),
        .stall_hold      (stall_hold),
        .stall_inc       (stall_inc)
    );

    collection_ctrl ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .start_seen      (start_seen),
        .end_seen        (end_seen),
        .rd_valid        (rd_valid),
        .rsp_credit      (rsp_credit),
        .count_en        (count_en),
        .count_clr       (count_clr),
        .collecting      (collecting),
        .collection_done (collection_done),
        .rd_ready        (rd_ready),
        .rd_accept       (rd_accept)
    );

    counter_bank #(
        .NUM_EVENTS (stats_pkg::NUM_COUNTERS)
    ) bank (
        .clk       (clk),
        .arst_n    (arst_n),
        .mix_inc   (mix_inc),
        .stall_inc (stall_inc),
        .count_en  (count_en),
        .count_clr (count_clr),
        .rd_accept (rd_accept),
        .rd_index  (rd_index),
        .rsp_valid (rsp_valid),
        .rsp_index (rsp_index),
        .rsp_data  (rsp_data)
    );

endmodule

`default_nettype wire

// ==== include/tb_helpers.svh ====
////////////////////////////////////////////////////////////
// Testbench helpers, included inside the bench module.
// Random operands and instruction words per mix category.
////////////////////////////////////////////////////////////
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Word for a mix category index with operands from rnd
function automatic logic [31:0] build_instr(input int cat, input logic [31:0] rnd);
    logic [4:0] opc;
    logic [31:0] instr;
    case (cat)
        stats_pkg::CNT_ALU: opc = rnd[13] ? stats_pkg::OPC_ARITH_IMM : stats_pkg::OPC_LUI;
        stats_pkg::CNT_BR: opc = rnd[13] ? stats_pkg::OPC_BRANCH : stats_pkg::OPC_JALR;
        stats_pkg::CNT_MUL, stats_pkg::CNT_DIV: opc = stats_pkg::OPC_ARITH;
        stats_pkg::CNT_LOAD: opc = stats_pkg::OPC_LOAD;
        stats_pkg::CNT_STORE: opc = stats_pkg::OPC_STORE;
        default: opc = rnd[13] ? stats_pkg::OPC_SYSTEM : stats_pkg::OPC_FENCE;
    endcase
    // Nonzero rd keeps clear of the marker words
    instr = {rnd[31:12], rnd[11:7] | 5'd1, opc, 2'b11};
    if (cat == stats_pkg::CNT_MUL || cat == stats_pkg::CNT_DIV) begin
        instr[stats_pkg::MULDIV_BIT] = 1'b1;
        instr[stats_pkg::DIV_BIT] = (cat == stats_pkg::CNT_DIV);
    end
    return instr;
endfunction

`endif

// ==== bench/retire_stats_tb.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the retire statistics unit.
// A reference model tracks expected counts per input cycle;
// counters are read back through the credit-paced port.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module retire_stats_tb;

    logic clk = 1'b0;
    logic arst_n;
    logic [stats_pkg::RETIRE_PORTS-1:0] retire_valid;
    logic [stats_pkg::RETIRE_PORTS-1:0][stats_pkg::INSTR_W-1:0] retire_instr;
    logic stall_no_instr;
    logic stall_unit_busy;
    logic stall_operands;
    logic stall_hold;
    logic rd_valid;
    logic [stats_pkg::IDX_W-1:0] rd_index;
    logic rd_ready;
    logic rsp_valid;
    logic [stats_pkg::IDX_W-1:0] rsp_index;
    logic [stats_pkg::COUNT_W-1:0] rsp_data;
    logic rsp_credit;
    logic collecting;
    logic collection_done;

    logic [31:0] rnd;
    int unsigned exp_cnt [stats_pkg::NUM_COUNTERS];
    // 0 closed, 1 counting, 2 cycle swallowed by the clear
    int win_state;
    int errors;
    int tests_run;
    int tests_failed;

    `include "tb_helpers.svh"

    retire_stats_top UUT (
        .clk             (clk),
        .arst_n          (arst_n),
        .retire_valid    (retire_valid),
        .retire_instr    (retire_instr),
        .stall_no_instr  (stall_no_instr),
        .stall_unit_busy (stall_unit_busy),
        .stall_operands  (stall_operands),
        .stall_hold      (stall_hold),
        .rd_valid        (rd_valid),
        .rd_index        (rd_index),
        .rd_ready        (rd_ready),
        .rsp_valid       (rsp_valid),
        .rsp_index       (rsp_index),
        .rsp_data        (rsp_data),
        .rsp_credit      (rsp_credit),
        .collecting      (collecting),
        .collection_done (collection_done)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // Checks and model
    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, expected);
            errors++;
        end
    endtask

    function automatic logic [31:0] next_rand();
        rnd = xorshift32(rnd);
        return rnd;
    endfunction

    // One input cycle as the window and attribution rules see it
    function automatic void update_model(input logic [1:0] v, input logic [31:0] i0,
                                         input int c0, input logic [31:0] i1, input int c1,
                                         input logic [3:0] st);
        bit has_start;
        bit has_end;
        int active;
        has_start = (v[0] && i0 == stats_pkg::START_MARKER)
                    || (v[1] && i1 == stats_pkg::START_MARKER);
        has_end = (v[0] && i0 == stats_pkg::END_MARKER) || (v[1] && i1 == stats_pkg::END_MARKER);
        if (win_state == 1) begin
            if (v[0] && i0 != stats_pkg::START_MARKER && i0 != stats_pkg::END_MARKER)
                exp_cnt[c0]++;
            if (v[1] && i1 != stats_pkg::START_MARKER && i1 != stats_pkg::END_MARKER)
                exp_cnt[c1]++;
            active = $countones(st);
            if (active == 1) begin
                for (int b = 0; b < 4; b++)
                    if (st[b])
                        exp_cnt[stats_pkg::CNT_STALL_NO_INSTR + b]++;
            end else if (active > 1) begin
                exp_cnt[stats_pkg::CNT_STALL_MULTI]++;
            end
            if (has_end)
                win_state = 0;
        end else if (win_state == 2) begin
            win_state = 1;
        end
        if (has_start) begin
            foreach (exp_cnt[i])
                exp_cnt[i] = 0;
            win_state = 2;
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus
    task automatic drive_cycle(input logic [1:0] v, input logic [31:0] i0, input int c0,
                               input logic [31:0] i1, input int c1, input logic [3:0] st);
        @(posedge clk);
        retire_valid <= v;
        retire_instr[0] <= i0;
        retire_instr[1] <= i1;
        stall_no_instr <= st[0];
        stall_unit_busy <= st[1];
        stall_operands <= st[2];
        stall_hold <= st[3];
        update_model(v, i0, c0, i1, c1, st);
    endtask

    task automatic drive_idle();
        drive_cycle(2'b00, '0, 0, '0, 0, 4'h0);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (collection_done !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (collection_done !== 1'b1) begin
            $display("Timed out waiting for collection_done at %0t", $time);
            errors++;
        end
    endtask

    // One request, one response, then the credit goes back
    task automatic read_counter(input int idx, output logic [31:0] data);
        int n;
        logic granted;
        data = '0;
        @(posedge clk);
        rd_valid <= 1'b1;
        rd_index <= idx[stats_pkg::IDX_W-1:0];
        n = 0;
        @(negedge clk);
        while (rd_ready !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        granted = (rd_ready === 1'b1);
        @(posedge clk);
        rd_valid <= 1'b0;
        if (!granted) begin
            $display("Timed out waiting for rd_ready reading index %0d", idx);
            errors++;
            return;
        end
        n = 0;
        @(negedge clk);
        while (rsp_valid !== 1'b1 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (rsp_valid !== 1'b1) begin
            $display("No response arrived for read of index %0d", idx);
            errors++;
            return;
        end
        check_word("rsp_index", 32'(rsp_index), idx);
        data = rsp_data;
        @(posedge clk);
        rsp_credit <= 1'b1;
        @(posedge clk);
        rsp_credit <= 1'b0;
    endtask

    task automatic check_counters(input int first, input int last);
        logic [31:0] d;
        for (int i = first; i <= last; i++) begin
            read_counter(i, d);
            check_word($sformatf("counter[%0d]", i), d, exp_cnt[i]);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    task automatic after_reset();
        int e;
        logic [31:0] d;
        e = errors;
        @(negedge clk);
        check_bit("collecting", collecting, 1'b0);
        check_bit("collection_done", collection_done, 1'b0);
        check_bit("rsp_valid", rsp_valid, 1'b0);
        check_bit("rd_ready", rd_ready, 1'b1);
        check_counters(0, stats_pkg::NUM_COUNTERS - 1);
        read_counter(15, d);
        check_word("counter[15]", d, 32'd0);
        finish_test("after_reset", e);
    endtask

    task automatic instruction_mix();
        int e;
        int c0;
        int c1;
        logic [31:0] r;
        e = errors;
        drive_cycle(2'b01, stats_pkg::START_MARKER, 0, '0, 0, 4'h0);
        drive_idle();
        for (int k = 0; k < 60; k++) begin
            r = next_rand();
            // Port 0 walks every category in turn
            c0 = k % stats_pkg::NUM_MIX;
            c1 = int'(r[31:16] % 16'd7);
            drive_cycle(r[1:0], build_instr(c0, next_rand()), c0,
                        build_instr(c1, next_rand()), c1, 4'h0);
        end
        drive_cycle(2'b11, stats_pkg::END_MARKER, 0,
                    build_instr(stats_pkg::CNT_STORE, next_rand()), stats_pkg::CNT_STORE, 4'h0);
        drive_idle();
        wait_done();
        check_bit("collection_done", collection_done, 1'b1);
        check_counters(0, stats_pkg::CNT_MISC);
        finish_test("instruction_mix", e);
    endtask

    task automatic window_edges();
        int e;
        e = errors;
        drive_cycle(2'b11, build_instr(stats_pkg::CNT_ALU, next_rand()), stats_pkg::CNT_ALU,
                    build_instr(stats_pkg::CNT_LOAD, next_rand()), stats_pkg::CNT_LOAD, 4'h0);
        drive_cycle(2'b11, stats_pkg::START_MARKER, 0,
                    build_instr(stats_pkg::CNT_ALU, next_rand()), stats_pkg::CNT_ALU, 4'h0);
        drive_idle();
        for (int k = 0; k < 3; k++)
            drive_cycle(2'b11, build_instr(k, next_rand()), k,
                        build_instr(k + 4, next_rand()), k + 4, 4'h0);
        // Branch shares the end-marker cycle
        drive_cycle(2'b11, build_instr(stats_pkg::CNT_BR, next_rand()), stats_pkg::CNT_BR,
                    stats_pkg::END_MARKER, 0, 4'h0);
        drive_cycle(2'b11, build_instr(stats_pkg::CNT_MUL, next_rand()), stats_pkg::CNT_MUL,
                    build_instr(stats_pkg::CNT_DIV, next_rand()), stats_pkg::CNT_DIV, 4'h0);
        drive_idle();
        wait_done();
        check_counters(0, stats_pkg::CNT_MISC);
        // Second window wipes the bank
        drive_cycle(2'b01, stats_pkg::START_MARKER, 0, '0, 0, 4'h0);
        drive_idle();
        drive_idle();
        @(negedge clk);
        check_bit("collecting", collecting, 1'b1);
        check_bit("collection_done", collection_done, 1'b0);
        check_counters(0, stats_pkg::NUM_COUNTERS - 1);
        finish_test("window_edges", e);
    endtask

    task automatic stall_attribution();
        int e;
        logic [3:0] pats [12];
        e = errors;
        pats = '{4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC, 4'h5, 4'hF, 4'h1, 4'h8, 4'hA};
        drive_cycle(2'b01, stats_pkg::START_MARKER, 0, '0, 0, 4'h0);
        drive_idle();
        foreach (pats[i])
            drive_cycle(2'b00, '0, 0, '0, 0, pats[i]);
        for (int k = 0; k < 10; k++)
            drive_cycle(2'b00, '0, 0, '0, 0, 4'(next_rand() >> 28));
        drive_cycle(2'b01, stats_pkg::END_MARKER, 0, '0, 0, 4'h4);
        drive_idle();
        wait_done();
        check_counters(stats_pkg::CNT_STALL_NO_INSTR, stats_pkg::CNT_STALL_MULTI);
        finish_test("stall_attribution", e);
    endtask

    task automatic credit_flow();
        int e;
        int accepted;
        int cur;
        int pend_idx;
        logic pend;
        e = errors;
        accepted = 0;
        cur = stats_pkg::CNT_STALL_NO_INSTR;
        pend = 1'b0;
        pend_idx = 0;
        @(posedge clk);
        rd_valid <= 1'b1;
        rd_index <= cur[stats_pkg::IDX_W-1:0];
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            check_bit("rd_ready", rd_ready, accepted < stats_pkg::CREDITS);
            check_bit("rsp_valid", rsp_valid, pend);
            if (pend) begin
                check_word("rsp_index", 32'(rsp_index), pend_idx);
                check_word("rsp_data", rsp_data, exp_cnt[pend_idx]);
            end
            pend = rd_ready;
            pend_idx = cur;
            if (rd_ready)
                accepted++;
            @(posedge clk);
            if (pend) begin
                cur++;
                rd_index <= cur[stats_pkg::IDX_W-1:0];
            end
        end
        rd_valid <= 1'b0;
        check_word("accepted", accepted, stats_pkg::CREDITS);
        rsp_credit <= 1'b1;
        @(posedge clk);
        rsp_credit <= 1'b0;
        @(negedge clk);
        check_bit("rd_ready", rd_ready, 1'b1);
        repeat (stats_pkg::CREDITS - 1) begin
            @(posedge clk);
            rsp_credit <= 1'b1;
            @(posedge clk);
            rsp_credit <= 1'b0;
        end
        finish_test("credit_flow", e);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequence
    initial begin
        arst_n = 1'b0;
        retire_valid = '0;
        retire_instr = '0;
        stall_no_instr = 1'b0;
        stall_unit_busy = 1'b0;
        stall_operands = 1'b0;
        stall_hold = 1'b0;
        rd_valid = 1'b0;
        rd_index = '0;
        rsp_credit = 1'b0;
        rnd = 32'h14d;
        win_state = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        foreach (exp_cnt[i])
            exp_cnt[i] = 0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        after_reset();
        instruction_mix();
        window_edges();
        stall_attribution();
        credit_flow();
        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    // Whole-run limit
    initial begin
        #200000;
        $display("Simulation time limit reached before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
rtl/stats_pkg.sv
rtl/retire_classifier.sv
rtl/stall_classifier.sv
rtl/counter_bank.sv
rtl/collection_ctrl.sv
rtl/retire_stats_top.sv
bench/retire_stats_tb.sv

// ==== Makefile ====
# Verilator flow for the retire-trace statistics unit

VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = retire_stats_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
